// ==== tb.f ====
source/addsub_pkg.sv
source/axis_if.sv
source/chdr_deframer.sv
source/addsub_core.sv
source/chdr_framer.sv
source/addsub_ctrl.sv
source/noc_block_addsub.sv
verif/addsub_properties.sv
verif/tb_noc_block_addsub.sv

// ==== Bender.yml ====
package:
  name: noc_block_addsub

sources:
  - source/addsub_pkg.sv
  - source/axis_if.sv
  - source/chdr_deframer.sv
  - source/addsub_core.sv
  - source/chdr_framer.sv
  - source/addsub_ctrl.sv
  - source/noc_block_addsub.sv
  - target: test
    files:
      - verif/addsub_properties.sv
      - verif/tb_noc_block_addsub.sv

// ==== verif/tb_noc_block_addsub.sv ====
// Testbench for the add/sub stream block
// Random packet pairs checked against a sum/diff model, plus register tests

`timescale 1ns/1ps

module tb_noc_block_addsub import addsub_pkg::*; ();

  localparam int N_PAIRS    = 32;
  localparam int MAX_CYCLES = 40 * N_PAIRS * 2 * 9 + 2000;

  logic ce_clk, i_rst, i_wb_cyc, i_wb_stb, i_wb_we, o_wb_ack;
  logic [2:0] i_wb_adr;
  logic [31:0] i_wb_dat, o_wb_dat;
  logic [DATA_W-1:0] i_a_tdata, i_b_tdata, o_sum_tdata, o_diff_tdata;
  logic i_a_tlast, i_a_tvalid, o_a_tready, i_b_tlast, i_b_tvalid, o_b_tready;
  logic o_sum_tlast, o_sum_tvalid, i_sum_tready, o_diff_tlast, o_diff_tvalid, i_diff_tready;

  logic [31:0] lfsr, sum_sid, diff_sid, rd;
  logic [64:0] sum_q[$], diff_q[$];
  logic [63:0] a_beats[0:8], b_beats[0:8];
  logic [11:0] sum_seq, diff_seq;
  logic        gaps_on, bp_on;
  int          n_checks, n_errors, test_checks, test_errors, cycles, pairs_sent, bad_pairs;
  string       test_name;

  noc_block_addsub #(.LANE_W(16), .HDR_DEPTH(4)) uut (.*);

  initial begin
    ce_clk = 1'b0;
    forever #20 ce_clk = ~ce_clk;
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic step_lfsr();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[62:0], step_lfsr()};
    return r;
  endfunction

  task automatic check(input string what, input logic [64:0] exp, input logic [64:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] %s, %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = n_checks;
    test_errors = n_errors;
  endtask

  task automatic end_test();
    $display("%s: %0d checks, %0d errors", test_name, n_checks - test_checks,
             n_errors - test_errors);
  endtask

  task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    @(negedge ce_clk);
    while (!o_wb_ack) @(negedge ce_clk);
    rd = o_wb_dat;
    @(posedge ce_clk);
    #2;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
  endtask

  task automatic read_check(input string what, input logic [2:0] adr, input logic [31:0] exp);
    wb_access(1'b0, adr, '0);
    check(what, exp, rd);
  endtask

  task automatic set_stream(input bit side, input logic v, input logic [63:0] d, input logic l);
    if (side) begin
      i_b_tvalid = v;
      i_b_tdata  = d;
      i_b_tlast  = l;
    end else begin
      i_a_tvalid = v;
      i_a_tdata  = d;
      i_a_tlast  = l;
    end
  endtask

  task automatic drive_stream(input bit side, input int n);
    for (int i = 0; i < n; i++) begin
      // Optional idle cycles before a beat
      while (gaps_on && step_lfsr() && step_lfsr()) begin
        set_stream(side, 1'b0, '0, 1'b0);
        @(posedge ce_clk);
        #2;
      end
      set_stream(side, 1'b1, side ? b_beats[i] : a_beats[i], i == n - 1);
      @(negedge ce_clk);
      while (!(side ? o_b_tready : o_a_tready)) @(negedge ce_clk);
      @(posedge ce_clk);
      #2;
    end
    set_stream(side, 1'b0, '0, 1'b0);
  endtask

  // Builds one A/B packet pair, queues the expected outputs, then drives both
  task automatic send_pair(input logic bad_len);
    int          beats;
    logic [15:0] len;
    logic [63:0] s, d;
    chdr_hdr_t   h;
    beats = 1 + int'(rand_bits(3));
    len = 16'((beats + 1) * 8);
    a_beats[0] = {4'h0, 12'(rand_bits(12)), len, 32'(rand_bits(32))};
    b_beats[0] = {4'h0, 12'(rand_bits(12)), bad_len ? len + 16'd8 : len, 32'(rand_bits(32))};
    h = '{pkt_type: 4'h0, seq: sum_seq, len: len, src_sid: sum_sid[31:16],
          dst_sid: sum_sid[15:0]};
    sum_q.push_back({1'b0, h});
    h.seq     = diff_seq;
    h.src_sid = diff_sid[31:16];
    h.dst_sid = diff_sid[15:0];
    diff_q.push_back({1'b0, h});
    for (int i = 1; i <= beats; i++) begin
      a_beats[i] = rand_bits(64);
      b_beats[i] = rand_bits(64);
      for (int l = 0; l < 4; l++) begin
        s[l*16 +: 16] = a_beats[i][l*16 +: 16] + b_beats[i][l*16 +: 16];
        d[l*16 +: 16] = a_beats[i][l*16 +: 16] - b_beats[i][l*16 +: 16];
      end
      sum_q.push_back({i == beats, s});
      diff_q.push_back({i == beats, d});
    end
    sum_seq++;
    diff_seq++;
    pairs_sent++;
    if (bad_len) bad_pairs++;
    fork
      drive_stream(1'b0, beats + 1);
      drive_stream(1'b1, beats + 1);
    join
  endtask

  task automatic wait_drain();
    while (sum_q.size() != 0 || diff_q.size() != 0) @(posedge ce_clk);
    repeat (4) @(posedge ce_clk);
    #2;
  endtask

  task automatic check_beat(input string what, ref logic [64:0] q[$], input logic [64:0] act);
    if (q.size() == 0) begin
      n_errors++;
      $display("Unexpected %s beat %h arrived with nothing left to expect", what, act);
    end else begin
      check(what, q.pop_front(), act);
    end
  endtask

  // Sampled mid-cycle, one half period after inputs settle
  always @(negedge ce_clk) begin
    if (!i_rst && o_sum_tvalid && i_sum_tready) begin
      check_beat("sum", sum_q, {o_sum_tlast, o_sum_tdata});
    end
    if (!i_rst && o_diff_tvalid && i_diff_tready) begin
      check_beat("diff", diff_q, {o_diff_tlast, o_diff_tdata});
    end
  end

  always @(posedge ce_clk) begin
    #2;
    i_sum_tready  = i_rst ? 1'b0 : (bp_on ? step_lfsr() : 1'b1);
    i_diff_tready = i_rst ? 1'b0 : (bp_on ? step_lfsr() : 1'b1);
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge ce_clk);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles before all tests finished", cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    lfsr = 32'h50d0c944;
    i_rst = 1'b1;
    {i_wb_cyc, i_wb_stb, i_wb_we, i_wb_adr, i_wb_dat} = '0;
    set_stream(1'b0, 1'b0, '0, 1'b0);
    set_stream(1'b1, 1'b0, '0, 1'b0);
    {i_sum_tready, i_diff_tready, gaps_on, bp_on} = '0;
    {sum_seq, diff_seq} = '0;
    {n_checks, n_errors, pairs_sent, bad_pairs} = '0;
    repeat (3) @(posedge ce_clk);
    #2;
    i_rst = 1'b0;

    start_test("registers");
    sum_sid  = 32'(rand_bits(32));
    diff_sid = 32'(rand_bits(32));
    wb_access(1'b1, REG_SUM_SID, sum_sid);
    wb_access(1'b1, REG_DIFF_SID, diff_sid);
    read_check("sum ids", REG_SUM_SID, sum_sid);
    read_check("diff ids", REG_DIFF_SID, diff_sid);
    wb_access(1'b1, REG_CTRL, 32'h2);
    read_check("ctrl", REG_CTRL, 32'h0);
    end_test();

    start_test("disabled");
    set_stream(1'b0, 1'b1, rand_bits(64), 1'b0);
    set_stream(1'b1, 1'b1, rand_bits(64), 1'b0);
    repeat (20) begin
      @(negedge ce_clk);
      check("a ready", 1'b0, o_a_tready);
      check("b ready", 1'b0, o_b_tready);
      check("output valid", 1'b0, o_sum_tvalid | o_diff_tvalid);
    end
    @(posedge ce_clk);
    #2;
    set_stream(1'b0, 1'b0, '0, 1'b0);
    set_stream(1'b1, 1'b0, '0, 1'b0);
    end_test();

    start_test("sum_diff");
    wb_access(1'b1, REG_CTRL, 32'h1);
    repeat (12) send_pair(1'b0);
    wait_drain();
    end_test();

    start_test("backpressure");
    gaps_on = 1'b1;
    bp_on   = 1'b1;
    repeat (12) send_pair(1'b0);
    wait_drain();
    gaps_on = 1'b0;
    bp_on   = 1'b0;
    end_test();

    start_test("seq_clear");
    wb_access(1'b1, REG_CTRL, 32'h3);
    sum_seq  = '0;
    diff_seq = '0;
    repeat (4) send_pair(1'b0);
    wait_drain();
    end_test();

    start_test("counters");
    send_pair(1'b1);
    send_pair(1'b0);
    send_pair(1'b1);
    send_pair(1'b0);
    wait_drain();
    read_check("packet count", REG_PKT_CNT, pairs_sent);
    read_check("length errors", REG_LEN_ERR, bad_pairs);
    end_test();

    if (uut.u_props.assert_failures != 0) begin
      $display("Protocol assertions failed %0d times during the run",
               uut.u_props.assert_failures);
      n_errors += uut.u_props.assert_failures;
    end

    $display("Summary: 6 tests, %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/addsub_properties.sv ====
// Protocol checks for the add/sub block, bound to its top level
// Output stream hold rules, Wishbone ack shape and reset values

`timescale 1ns/1ps

module addsub_properties import addsub_pkg::*; (
  input logic              ce_clk,
  input logic              i_rst,
  input logic              i_wb_cyc,
  input logic              i_wb_stb,
  input logic              o_wb_ack,
  input logic [DATA_W-1:0] o_sum_tdata,
  input logic              o_sum_tlast,
  input logic              o_sum_tvalid,
  input logic              i_sum_tready,
  input logic [DATA_W-1:0] o_diff_tdata,
  input logic              o_diff_tlast,
  input logic              o_diff_tvalid,
  input logic              i_diff_tready
);

  // Failure count for the testbench summary
  int assert_failures = 0;

  // A stalled beat stays put until it moves
  assert property (@(posedge ce_clk) disable iff (i_rst)
    o_sum_tvalid && !i_sum_tready |=> o_sum_tvalid && $stable({o_sum_tlast, o_sum_tdata}))
    else begin
      assert_failures++;
      $error("sum beat dropped or changed while stalled");
    end

  assert property (@(posedge ce_clk) disable iff (i_rst)
    o_diff_tvalid && !i_diff_tready |=> o_diff_tvalid && $stable({o_diff_tlast, o_diff_tdata}))
    else begin
      assert_failures++;
      $error("diff beat dropped or changed while stalled");
    end

  assert property (@(posedge ce_clk) disable iff (i_rst) o_wb_ack |=> !o_wb_ack)
    else begin
      assert_failures++;
      $error("wishbone ack longer than one cycle");
    end

  assert property (@(posedge ce_clk) disable iff (i_rst) o_wb_ack |-> i_wb_cyc && i_wb_stb)
    else begin
      assert_failures++;
      $error("wishbone ack without cyc and stb");
    end

  assert property (@(posedge ce_clk) i_rst |=> !o_sum_tvalid && !o_diff_tvalid && !o_wb_ack)
    else begin
      assert_failures++;
      $error("output valid or ack high right after reset");
    end

endmodule

bind noc_block_addsub addsub_properties u_props (.*);

// ==== source/noc_block_addsub.sv ====
// Two-input add/sub stream endpoint
// Strips A and B headers, emits framed sum and difference packets

`timescale 1ns/1ps

module noc_block_addsub import addsub_pkg::*; #(
  parameter int LANE_W    = 16,
  parameter int HDR_DEPTH = 4
) (
  input  logic              ce_clk,
  input  logic              i_rst,
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  logic [2:0]        i_wb_adr,
  input  logic [31:0]       i_wb_dat,
  output logic [31:0]       o_wb_dat,
  output logic              o_wb_ack,
  input  logic [DATA_W-1:0] i_a_tdata,
  input  logic              i_a_tlast,
  input  logic              i_a_tvalid,
  output logic              o_a_tready,
  input  logic [DATA_W-1:0] i_b_tdata,
  input  logic              i_b_tlast,
  input  logic              i_b_tvalid,
  output logic              o_b_tready,
  output logic [DATA_W-1:0] o_sum_tdata,
  output logic              o_sum_tlast,
  output logic              o_sum_tvalid,
  input  logic              i_sum_tready,
  output logic [DATA_W-1:0] o_diff_tdata,
  output logic              o_diff_tlast,
  output logic              o_diff_tvalid,
  input  logic              i_diff_tready
);

  axis_if a_pay ();
  axis_if b_pay ();
  axis_if sum_pay ();
  axis_if diff_pay ();

  chdr_hdr_t        a_hdr;
  chdr_hdr_t        b_hdr;
  chdr_hdr_t        cur_hdr;
  logic             a_hdr_valid;
  logic             a_hdr_ready;
  logic             b_hdr_valid;
  logic             b_hdr_ready;
  logic             sum_hdr_valid;
  logic             diff_hdr_valid;
  logic             sum_done;
  logic             diff_done;
  logic             last_mismatch;
  logic             enable;
  logic             seq_clear;
  logic [SID_W-1:0] sum_src_sid;
  logic [SID_W-1:0] sum_dst_sid;
  logic [SID_W-1:0] diff_src_sid;
  logic [SID_W-1:0] diff_dst_sid;

  chdr_deframer u_deframer_a (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_enable(enable),
    .i_tdata(i_a_tdata), .i_tlast(i_a_tlast), .i_tvalid(i_a_tvalid), .o_tready(o_a_tready),
    .o_hdr(a_hdr), .o_hdr_valid(a_hdr_valid), .i_hdr_ready(a_hdr_ready), .o_pay(a_pay));

  chdr_deframer u_deframer_b (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_enable(enable),
    .i_tdata(i_b_tdata), .i_tlast(i_b_tlast), .i_tvalid(i_b_tvalid), .o_tready(o_b_tready),
    .o_hdr(b_hdr), .o_hdr_valid(b_hdr_valid), .i_hdr_ready(b_hdr_ready), .o_pay(b_pay));

  addsub_core #(.LANE_W(LANE_W)) u_core (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_a(a_pay), .i_b(b_pay),
    .o_sum(sum_pay), .o_diff(diff_pay), .o_last_mismatch(last_mismatch));

  chdr_framer u_framer_sum (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_seq_clear(seq_clear),
    .i_hdr(cur_hdr), .i_hdr_valid(sum_hdr_valid),
    .i_src_sid(sum_src_sid), .i_dst_sid(sum_dst_sid), .i_pay(sum_pay),
    .o_tdata(o_sum_tdata), .o_tlast(o_sum_tlast), .o_tvalid(o_sum_tvalid),
    .i_tready(i_sum_tready), .o_pkt_done(sum_done));

  chdr_framer u_framer_diff (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_seq_clear(seq_clear),
    .i_hdr(cur_hdr), .i_hdr_valid(diff_hdr_valid),
    .i_src_sid(diff_src_sid), .i_dst_sid(diff_dst_sid), .i_pay(diff_pay),
    .o_tdata(o_diff_tdata), .o_tlast(o_diff_tlast), .o_tvalid(o_diff_tvalid),
    .i_tready(i_diff_tready), .o_pkt_done(diff_done));

  addsub_ctrl #(.HDR_DEPTH(HDR_DEPTH)) u_ctrl (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr),
    .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
    .i_a_hdr(a_hdr), .i_a_hdr_valid(a_hdr_valid), .o_a_hdr_ready(a_hdr_ready),
    .i_b_hdr(b_hdr), .i_b_hdr_valid(b_hdr_valid), .o_b_hdr_ready(b_hdr_ready),
    .i_last_mismatch(last_mismatch), .o_cur_hdr(cur_hdr),
    .o_sum_hdr_valid(sum_hdr_valid), .o_diff_hdr_valid(diff_hdr_valid),
    .i_sum_done(sum_done), .i_diff_done(diff_done),
    .o_enable(enable), .o_seq_clear(seq_clear),
    .o_sum_src_sid(sum_src_sid), .o_sum_dst_sid(sum_dst_sid),
    .o_diff_src_sid(diff_src_sid), .o_diff_dst_sid(diff_dst_sid));

endmodule

// ==== source/addsub_ctrl.sv ====
// Control block with the Wishbone register file and header queue
// Tracks per-packet completion of both framers and keeps the counters

`timescale 1ns/1ps

module addsub_ctrl import addsub_pkg::*; #(
  parameter int HDR_DEPTH = 4
) (
  input  logic             ce_clk,
  input  logic             i_rst,
  input  logic             i_wb_cyc,
  input  logic             i_wb_stb,
  input  logic             i_wb_we,
  input  logic [2:0]       i_wb_adr,
  input  logic [31:0]      i_wb_dat,
  output logic [31:0]      o_wb_dat,
  output logic             o_wb_ack,
  input  chdr_hdr_t        i_a_hdr,
  input  logic             i_a_hdr_valid,
  output logic             o_a_hdr_ready,
  input  chdr_hdr_t        i_b_hdr,
  input  logic             i_b_hdr_valid,
  output logic             o_b_hdr_ready,
  input  logic             i_last_mismatch,
  output chdr_hdr_t        o_cur_hdr,
  output logic             o_sum_hdr_valid,
  output logic             o_diff_hdr_valid,
  input  logic             i_sum_done,
  input  logic             i_diff_done,
  output logic             o_enable,
  output logic             o_seq_clear,
  output logic [SID_W-1:0] o_sum_src_sid,
  output logic [SID_W-1:0] o_sum_dst_sid,
  output logic [SID_W-1:0] o_diff_src_sid,
  output logic [SID_W-1:0] o_diff_dst_sid
);

  localparam int PTR_W = (HDR_DEPTH > 1) ? $clog2(HDR_DEPTH) : 1;
  localparam int CNT_W = $clog2(HDR_DEPTH + 1);

  chdr_hdr_t        hdr_q [HDR_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_count;
  logic             q_full;
  logic             q_empty;
  logic             push;
  logic             pop;
  logic             hdr_len_err;
  logic             sum_done;
  logic             diff_done;
  logic [31:0]      pkt_cnt;
  logic [31:0]      len_err_cnt;
  logic             wb_req;
  logic [31:0]      rd_data;

  //////////////////////////////////////////
  // Header queue
  //////////////////////////////////////////
  assign q_full  = (q_count == CNT_W'(HDR_DEPTH));
  assign q_empty = (q_count == '0);

  // A and B headers only ever move as a pair
  assign o_a_hdr_ready = !q_full && i_b_hdr_valid;
  assign o_b_hdr_ready = !q_full && i_a_hdr_valid;
  assign push          = !q_full && i_a_hdr_valid && i_b_hdr_valid;
  assign hdr_len_err   = push && (i_a_hdr.len != i_b_hdr.len);

  assign pop = !q_empty && (sum_done || i_sum_done) && (diff_done || i_diff_done);

  assign o_cur_hdr        = hdr_q[rd_ptr];
  assign o_sum_hdr_valid  = !q_empty && !sum_done;
  assign o_diff_hdr_valid = !q_empty && !diff_done;

  always_ff @(posedge ce_clk) begin
    if (push) begin
      hdr_q[wr_ptr] <= i_a_hdr;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      q_count   <= '0;
      sum_done  <= 1'b0;
      diff_done <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(HDR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(HDR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase

      if (pop) begin
        sum_done  <= 1'b0;
        diff_done <= 1'b0;
      end else begin
        if (i_sum_done) sum_done <= 1'b1;
        if (i_diff_done) diff_done <= 1'b1;
      end
    end
  end

  // Length errors come from headers and from tlast skew in the core
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      pkt_cnt     <= '0;
      len_err_cnt <= '0;
    end else begin
      if (pop) pkt_cnt <= pkt_cnt + 1'b1;
      len_err_cnt <= len_err_cnt + 32'(hdr_len_err) + 32'(i_last_mismatch);
    end
  end

  //////////////////////////////////////////
  // Wishbone slave
  //////////////////////////////////////////
  assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;

  always_comb begin
    case (i_wb_adr)
      REG_CTRL:     rd_data = {31'd0, o_enable};
      REG_SUM_SID:  rd_data = {o_sum_src_sid, o_sum_dst_sid};
      REG_DIFF_SID: rd_data = {o_diff_src_sid, o_diff_dst_sid};
      REG_PKT_CNT:  rd_data = pkt_cnt;
      REG_LEN_ERR:  rd_data = len_err_cnt;
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_wb_ack       <= 1'b0;
      o_enable       <= 1'b0;
      o_seq_clear    <= 1'b0;
      o_sum_src_sid  <= '0;
      o_sum_dst_sid  <= '0;
      o_diff_src_sid <= '0;
      o_diff_dst_sid <= '0;
    end else begin
      o_wb_ack    <= wb_req;
      o_seq_clear <= 1'b0;
      if (wb_req && i_wb_we) begin
        case (i_wb_adr)
          REG_CTRL: begin
            o_enable    <= i_wb_dat[CTRL_ENABLE_BIT];
            o_seq_clear <= i_wb_dat[CTRL_SEQ_CLR_BIT];
          end
          REG_SUM_SID: begin
            o_sum_src_sid <= i_wb_dat[31:16];
            o_sum_dst_sid <= i_wb_dat[15:0];
          end
          REG_DIFF_SID: begin
            o_diff_src_sid <= i_wb_dat[31:16];
            o_diff_dst_sid <= i_wb_dat[15:0];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (wb_req) begin
      o_wb_dat <= rd_data;
    end
  end

endmodule

// ==== source/chdr_framer.sv ====
// Output framer for one result stream
// Prepends a fresh header word and keeps the stream's sequence count

`timescale 1ns/1ps

module chdr_framer import addsub_pkg::*; (
  input  logic              ce_clk,
  input  logic              i_rst,
  input  logic              i_seq_clear,
  input  chdr_hdr_t         i_hdr,
  input  logic              i_hdr_valid,
  input  logic [SID_W-1:0]  i_src_sid,
  input  logic [SID_W-1:0]  i_dst_sid,
  axis_if.sink              i_pay,
  output logic [DATA_W-1:0] o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  logic              i_tready,
  output logic              o_pkt_done
);

  framer_state_t     state;
  logic [SEQ_W-1:0]  seq;
  logic [DATA_W-1:0] hdr_next;
  logic [DATA_W-1:0] hdr_word;
  logic              start;
  logic              hdr_xfer;

  always_comb begin
    hdr_next = '0;
    hdr_next[HDR_TYPE_LSB +: TYPE_W] = PKT_TYPE_DATA;
    hdr_next[HDR_SEQ_LSB +: SEQ_W]   = seq;
    hdr_next[HDR_LEN_LSB +: LEN_W]   = i_hdr.len;
    hdr_next[HDR_SRC_LSB +: SID_W]   = i_src_sid;
    hdr_next[HDR_DST_LSB +: SID_W]   = i_dst_sid;
  end

  assign start    = (state == IDLE) && i_hdr_valid && i_pay.tvalid;
  assign hdr_xfer = (state == HEADER) && i_tready;

  assign o_tvalid    = (state == HEADER) || ((state == PAYLOAD) && i_pay.tvalid);
  assign o_tdata     = (state == HEADER) ? hdr_word : i_pay.tdata;
  assign o_tlast     = (state == PAYLOAD) && i_pay.tlast;
  assign i_pay.tready = (state == PAYLOAD) && i_tready;
  assign o_pkt_done  = (state == PAYLOAD) && i_pay.tvalid && i_tready && i_pay.tlast;

  //////////////////////////////////////////
  // Framing FSM
  //////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      state <= IDLE;
      seq   <= '0;
    end else begin
      case (state)
        IDLE:    if (start) state <= HEADER;
        HEADER:  if (hdr_xfer) state <= PAYLOAD;
        PAYLOAD: if (o_pkt_done) state <= IDLE;
        default: state <= IDLE;
      endcase

      // Clear wins over the per-packet step
      if (i_seq_clear) begin
        seq <= '0;
      end else if (hdr_xfer) begin
        seq <= seq + 1'b1;
      end
    end
  end

  // Header held steady while it waits for ready
  always_ff @(posedge ce_clk) begin
    if (start) begin
      hdr_word <= hdr_next;
    end
  end

endmodule

// ==== source/addsub_core.sv ====
// Lane-wise adder and subtractor for two joined payload streams
// Results are registered, one slot per output

`timescale 1ns/1ps

module addsub_core import addsub_pkg::*; #(
  parameter int LANE_W = 16
) (
  input  logic   ce_clk,
  input  logic   i_rst,
  axis_if.sink   i_a,
  axis_if.sink   i_b,
  axis_if.source o_sum,
  axis_if.source o_diff,
  output logic   o_last_mismatch
);

  localparam int LANES = DATA_W / LANE_W;

  logic [DATA_W-1:0] sum_next;
  logic [DATA_W-1:0] diff_next;
  logic              sum_free;
  logic              diff_free;
  logic              can_load;
  logic              load;

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    logic [LANE_W-1:0] a_lane;
    logic [LANE_W-1:0] b_lane;

    assign a_lane = i_a.tdata[l*LANE_W +: LANE_W];
    assign b_lane = i_b.tdata[l*LANE_W +: LANE_W];

    // Wraps modulo 2^LANE_W
    assign sum_next[l*LANE_W +: LANE_W]  = a_lane + b_lane;
    assign diff_next[l*LANE_W +: LANE_W] = a_lane - b_lane;
  end

  assign sum_free  = !o_sum.tvalid || o_sum.tready;
  assign diff_free = !o_diff.tvalid || o_diff.tready;
  assign can_load  = sum_free && diff_free;

  // Both inputs move together
  assign i_a.tready = can_load && i_b.tvalid;
  assign i_b.tready = can_load && i_a.tvalid;
  assign load       = can_load && i_a.tvalid && i_b.tvalid;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_sum.tvalid    <= 1'b0;
      o_diff.tvalid   <= 1'b0;
      o_last_mismatch <= 1'b0;
    end else begin
      o_last_mismatch <= load && (i_a.tlast != i_b.tlast);
      if (load) begin
        o_sum.tvalid  <= 1'b1;
        o_diff.tvalid <= 1'b1;
      end else begin
        if (o_sum.tready) o_sum.tvalid <= 1'b0;
        if (o_diff.tready) o_diff.tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (load) begin
      o_sum.tdata  <= sum_next;
      o_sum.tlast  <= i_a.tlast;
      o_diff.tdata <= diff_next;
      o_diff.tlast <= i_a.tlast;
    end
  end

endmodule

// ==== source/chdr_deframer.sv ====
// Header stripper for one input stream
// Header word goes to the control path, payload passes straight through

`timescale 1ns/1ps

module chdr_deframer import addsub_pkg::*; (
  input  logic              ce_clk,
  input  logic              i_rst,
  input  logic              i_enable,
  input  logic [DATA_W-1:0] i_tdata,
  input  logic              i_tlast,
  input  logic              i_tvalid,
  output logic              o_tready,
  output chdr_hdr_t         o_hdr,
  output logic              o_hdr_valid,
  input  logic              i_hdr_ready,
  axis_if.source            o_pay
);

  logic at_header;
  logic hdr_slot_free;
  logic hdr_accept;
  logic pay_last_xfer;

  // Header slot is free when empty or handing over this cycle
  assign hdr_slot_free = !o_hdr_valid || i_hdr_ready;

  assign o_tready = i_enable && (at_header ? hdr_slot_free : o_pay.tready);

  assign hdr_accept    = at_header && i_tvalid && o_tready;
  assign pay_last_xfer = !at_header && i_tvalid && o_tready && i_tlast;

  // Payload path is combinational
  assign o_pay.tdata  = i_tdata;
  assign o_pay.tlast  = i_tlast;
  assign o_pay.tvalid = i_enable && !at_header && i_tvalid;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      at_header   <= 1'b1;
      o_hdr_valid <= 1'b0;
    end else begin
      if (hdr_accept) begin
        at_header <= 1'b0;
      end else if (pay_last_xfer) begin
        at_header <= 1'b1;
      end

      if (hdr_accept) begin
        o_hdr_valid <= 1'b1;
      end else if (i_hdr_ready) begin
        o_hdr_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (hdr_accept) begin
      o_hdr <= chdr_hdr_t'(i_tdata);
    end
  end

endmodule

// ==== source/axis_if.sv ====
// Stream interface between the internal blocks
// One beat moves when tvalid and tready are both high

`timescale 1ns/1ps

interface axis_if import addsub_pkg::*; ();

  logic [DATA_W-1:0] tdata;
  logic              tlast;
  logic              tvalid;
  logic              tready;

  modport source (
    output tdata,
    output tlast,
    output tvalid,
    input  tready
  );

  modport sink (
    input  tdata,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

// ==== source/addsub_pkg.sv ====
// Shared definitions for the add/sub stream block
// Header word layout, register map and framer states

package addsub_pkg;

  localparam int DATA_W = 64;

  // Header field widths
  localparam int TYPE_W = 4;
  localparam int SEQ_W  = 12;
  localparam int LEN_W  = 16;
  localparam int SID_W  = 16;

  // Header field positions within the 64-bit word
  localparam int HDR_TYPE_LSB = 60;
  localparam int HDR_SEQ_LSB  = 48;
  localparam int HDR_LEN_LSB  = 32;
  localparam int HDR_SRC_LSB  = 16;
  localparam int HDR_DST_LSB  = 0;

  localparam logic [TYPE_W-1:0] PKT_TYPE_DATA = '0;

  typedef struct packed {
    logic [TYPE_W-1:0] pkt_type;
    logic [SEQ_W-1:0]  seq;
    logic [LEN_W-1:0]  len;
    logic [SID_W-1:0]  src_sid;
    logic [SID_W-1:0]  dst_sid;
  } chdr_hdr_t;

  // Wishbone word addresses
  localparam logic [2:0] REG_CTRL     = 3'd0;
  localparam logic [2:0] REG_SUM_SID  = 3'd1;
  localparam logic [2:0] REG_DIFF_SID = 3'd2;
  localparam logic [2:0] REG_PKT_CNT  = 3'd3;
  localparam logic [2:0] REG_LEN_ERR  = 3'd4;

  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_SEQ_CLR_BIT = 1;

  typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD} framer_state_t;

endpackage
